/* Bender.yml */
package:
  name: dmac

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/dmac_pkg.sv
      - source/dmac_burst_sizer.sv
      - source/dmac_beat_fifo.sv
      - source/dmac_channel_ctrl.sv
      - source/dmac_core.sv
  - target: test
    files:
      - test/dmac_mem_model.sv
      - test/dmac_tb.sv

/* dmac.f */
+incdir+source
source/dmac_pkg.sv
source/dmac_burst_sizer.sv
source/dmac_beat_fifo.sv
source/dmac_channel_ctrl.sv
source/dmac_core.sv
test/dmac_mem_model.sv
test/dmac_tb.sv

/* test/dmac_tb.sv */
module dmac_tb import dmac_pkg::*; ();

    localparam int TIMEOUT = 5000;

    logic       clk;
    logic       arst_n;
    logic       tx;
    addr_t      src;
    addr_t      dst;
    addr_t      nbytes;
    logic       busy;
    logic       done;
    logic       err;
    tl_a_req_t  tl_a;
    logic       a_valid;
    logic       a_ready;
    tl_d_rsp_t  tl_d;
    logic       d_valid;
    logic       d_ready;
    logic [7:0] stall_pct;
    logic       deny_en;
    addr_t      deny_addr;

    logic [2:0] exp_op   [64];
    lgsize_t    exp_size [64];
    addr_t      exp_addr [64];
    int         exp_count;
    string      cur_test;

    dmac_core UUT (
        .dmac_clock_i (clk),
        .arst_n_i     (arst_n),
        .tx_i         (tx),
        .src_addr_i   (src),
        .dst_addr_i   (dst),
        .bytes_i      (nbytes),
        .busy_o       (busy),
        .done_o       (done),
        .err_o        (err),
        .tl_a_o       (tl_a),
        .tl_a_valid_o (a_valid),
        .tl_a_ready_i (a_ready),
        .tl_d_i       (tl_d),
        .tl_d_valid_i (d_valid),
        .tl_d_ready_o (d_ready)
    );

    dmac_mem_model u_mem (
        .dmac_clock_i (clk),
        .arst_n_i     (arst_n),
        .stall_pct_i  (stall_pct),
        .deny_en_i    (deny_en),
        .deny_addr_i  (deny_addr),
        .tl_a_i       (tl_a),
        .tl_a_valid_i (a_valid),
        .tl_a_ready_o (a_ready),
        .tl_d_o       (tl_d),
        .tl_d_valid_o (d_valid),
        .tl_d_ready_i (d_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [7:0] pattern_byte(input logic [31:0] addr);
        return (addr[7:0] + {2'b00, addr[13:8]}) ^ 8'h5a;
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s %s: expected 0x%0h, actual 0x%0h",
                     cur_test, what, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s in %s", msg, cur_test);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic init_memory();
        for (int i = 0; i < 16384; i++) begin
            u_mem.mem[i] = pattern_byte(i);
        end
        u_mem.log_count = 0;
    endtask

    // largest power of two up to 128 dividing both addresses and the remainder
    task automatic predict_requests(input addr_t s, input addr_t d, input addr_t n);
        int size;
        int lg;
        exp_count = 0;
        while (n != 0) begin
            size = 128;
            lg   = 7;
            while ((s % size) != 0 || (d % size) != 0 || (n % size) != 0) begin
                size = size / 2;
                lg   = lg - 1;
            end
            exp_op[exp_count]       = TL_GET;
            exp_size[exp_count]     = lg;
            exp_addr[exp_count]     = s;
            exp_op[exp_count + 1]   = TL_PUT_FULL_DATA;
            exp_size[exp_count + 1] = lg;
            exp_addr[exp_count + 1] = d;
            exp_count += 2;
            s += size;
            d += size;
            n -= size;
        end
    endtask

    task automatic compare_log(input int count);
        check_value("request count", count, u_mem.log_count);
        for (int i = 0; i < count; i++) begin
            check_value($sformatf("request %0d opcode", i), exp_op[i], u_mem.log_op[i]);
            check_value($sformatf("request %0d size", i), exp_size[i], u_mem.log_size[i]);
            check_value($sformatf("request %0d address", i), exp_addr[i], u_mem.log_addr[i]);
        end
    endtask

    task automatic check_untouched(input addr_t d, input addr_t n);
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("untouched byte 0x%0h", d + i),
                        pattern_byte(d + i), u_mem.mem[d + i]);
        end
    endtask

    task automatic check_copy(input addr_t s, input addr_t d, input addr_t n);
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("byte 0x%0h", d + i), pattern_byte(s + i), u_mem.mem[d + i]);
        end
        // neighbours show a mask spilling over the burst edges
        check_untouched(d - 1, 1);
        check_untouched(d + n, 1);
    endtask

    task automatic start_transfer(input addr_t s, input addr_t d, input addr_t n);
        @(posedge clk);
        tx     <= 1'b1;
        src    <= s;
        dst    <= d;
        nbytes <= n;
        @(posedge clk);
        tx     <= 1'b0;
    endtask

    task automatic wait_done(output int cycles, output logic err_at_done);
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles == 1) begin
                check_value("busy_o after tx_i", 1, busy);
            end
            if (err === 1'b1 && done !== 1'b1) begin
                report_failure("err_o was raised without done_o");
            end
            if (done !== 1'b1 && cycles >= TIMEOUT) begin
                report_failure("timed out waiting for done_o");
            end
        end while (done !== 1'b1);
        err_at_done = err;
        check_value("busy_o with done_o", 1, busy);
        @(posedge clk);
        check_value("busy_o after done_o", 0, busy);
        check_value("done_o pulse width", 0, done);
        check_value("err_o pulse width", 0, err);
    endtask

    task automatic wait_requests(input int n);
        int cycles;
        cycles = 0;
        while (u_mem.log_count < n) begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                report_failure("timed out waiting for channel A requests");
            end
        end
    endtask

    task automatic run_copy(input addr_t s, input addr_t d, input addr_t n);
        int   cycles;
        logic err_at_done;
        init_memory();
        predict_requests(s, d, n);
        start_transfer(s, d, n);
        wait_done(cycles, err_at_done);
        check_value("err_o at done", 0, err_at_done);
        compare_log(exp_count);
        check_copy(s, d, n);
    endtask

    task automatic test_aligned_copy();
        cur_test = "test_aligned_copy";
        run_copy(32'h1000, 32'h2000, 32'd256);
    endtask

    task automatic test_unaligned_copy();
        cur_test = "test_unaligned_copy";
        run_copy(32'h1003, 32'h3005, 32'd45);
    endtask

    task automatic test_zero_length();
        int   cycles;
        logic err_at_done;
        cur_test = "test_zero_length";
        init_memory();
        start_transfer(32'h1000, 32'h2000, 32'd0);
        wait_done(cycles, err_at_done);
        // counted from the edge that samples tx_i
        check_value("done_o latency", 2, cycles);
        check_value("err_o at done", 0, err_at_done);
        check_value("request count", 0, u_mem.log_count);
    endtask

    task automatic test_backpressure();
        cur_test = "test_backpressure";
        @(posedge clk);
        stall_pct <= 8'd40;
        run_copy(32'h1000, 32'h2000, 32'd128);
        stall_pct <= 8'd0;
    endtask

    task automatic test_denied_read();
        int   cycles;
        logic err_at_done;
        cur_test = "test_denied_read";
        @(posedge clk);
        deny_en   <= 1'b1;
        deny_addr <= 32'h1080;
        init_memory();
        predict_requests(32'h1000, 32'h2000, 32'd256);
        start_transfer(32'h1000, 32'h2000, 32'd256);
        wait_done(cycles, err_at_done);
        check_value("err_o at done", 1, err_at_done);
        compare_log(3);
        check_copy(32'h1000, 32'h2000, 32'd128);
        check_untouched(32'h2080, 32'd128);
        deny_en <= 1'b0;
    endtask

    task automatic test_start_while_busy();
        int   cycles;
        int   extra;
        logic err_at_done;
        cur_test = "test_start_while_busy";
        init_memory();
        predict_requests(32'h1000, 32'h2000, 32'd256);
        start_transfer(32'h1000, 32'h2000, 32'd256);
        wait_requests(2);
        start_transfer(32'h0400, 32'h2800, 32'd64);
        wait_done(cycles, err_at_done);
        extra = 0;
        repeat (100) begin
            @(posedge clk);
            if (done === 1'b1) begin
                extra++;
            end
        end
        check_value("extra done_o pulses", 0, extra);
        check_value("err_o at done", 0, err_at_done);
        compare_log(exp_count);
        check_copy(32'h1000, 32'h2000, 32'd256);
        check_untouched(32'h2800, 32'd64);
    endtask

    initial begin
        int seed;
        seed        = $urandom(35280);
        cur_test    = "reset";
        arst_n      = 1'b0;
        tx          = 1'b0;
        src         = '0;
        dst         = '0;
        nbytes      = '0;
        stall_pct   = '0;
        deny_en     = 1'b0;
        deny_addr   = '0;
        init_memory();
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_value("busy_o", 0, busy);
        check_value("done_o", 0, done);
        check_value("err_o", 0, err);
        check_value("tl_a_valid_o", 0, a_valid);
        test_aligned_copy();
        test_unaligned_copy();
        test_zero_length();
        test_backpressure();
        test_denied_read();
        test_start_while_busy();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* test/dmac_mem_model.sv */
module dmac_mem_model import dmac_pkg::*; (
    input  wire logic       dmac_clock_i,
    input  wire logic       arst_n_i,
    input  wire logic [7:0] stall_pct_i,
    input  wire logic       deny_en_i,
    input  wire addr_t      deny_addr_i,
    input  wire tl_a_req_t  tl_a_i,
    input  wire logic       tl_a_valid_i,
    output logic            tl_a_ready_o,
    output tl_d_rsp_t       tl_d_o,
    output logic            tl_d_valid_o,
    input  wire logic       tl_d_ready_i
);

    logic [7:0] mem [16384];

    // first beat of every burst seen on channel a
    logic [2:0] log_op   [64];
    lgsize_t    log_size [64];
    addr_t      log_addr [64];
    int         log_count;

    logic       putting;
    logic       responding;
    logic       rsp_data;
    logic       rsp_denied;
    addr_t      base;
    int         beat_idx;
    int         beat_total;
    int         delay_cnt;

    function automatic int beats_of(input lgsize_t size);
        return (size < 2) ? 1 : (1 << size) / 4;
    endfunction

    function automatic logic draw_stall();
        return $urandom_range(99, 0) < stall_pct_i;
    endfunction

    always @(posedge dmac_clock_i or negedge arst_n_i) begin : serve
        tl_d_rsp_t rsp;
        addr_t     a;
        int        idx;
        int        total;
        if (!arst_n_i) begin
            tl_a_ready_o <= 1'b0;
            tl_d_valid_o <= 1'b0;
            tl_d_o       <= '0;
            putting      <= 1'b0;
            responding   <= 1'b0;
            log_count    <= 0;
        end else if (!responding) begin
            tl_a_ready_o <= !draw_stall();
            if (tl_a_valid_i && tl_a_ready_o) begin
                idx   = putting ? beat_idx : 0;
                total = putting ? beat_total : beats_of(tl_a_i.size);
                a     = putting ? base + addr_t'(4 * beat_idx) : tl_a_i.address & ~addr_t'(3);
                if (!putting) begin
                    log_op[log_count]   <= tl_a_i.opcode;
                    log_size[log_count] <= tl_a_i.size;
                    log_addr[log_count] <= tl_a_i.address;
                    log_count           <= log_count + 1;
                    base                <= a;
                    beat_total          <= total;
                end
                if (tl_a_i.opcode == TL_GET) begin
                    rsp_data     <= 1'b1;
                    rsp_denied   <= deny_en_i && (tl_a_i.address == deny_addr_i);
                    tl_a_ready_o <= 1'b0;
                    responding   <= 1'b1;
                    beat_idx     <= 0;
                    delay_cnt    <= $urandom_range(3, 0);
                end else begin
                    for (int j = 0; j < 4; j++) begin
                        if (tl_a_i.mask[j]) begin
                            mem[a + j] <= tl_a_i.data[8*j +: 8];
                        end
                    end
                    if (idx == total - 1) begin
                        // whole put burst taken, answer with one AccessAck
                        putting      <= 1'b0;
                        rsp_data     <= 1'b0;
                        rsp_denied   <= 1'b0;
                        beat_total   <= 1;
                        tl_a_ready_o <= 1'b0;
                        responding   <= 1'b1;
                        beat_idx     <= 0;
                        delay_cnt    <= $urandom_range(3, 0);
                    end else begin
                        putting  <= 1'b1;
                        beat_idx <= idx + 1;
                    end
                end
            end
        end else if (delay_cnt != 0) begin
            delay_cnt <= delay_cnt - 1;
        end else if (!tl_d_valid_o || tl_d_ready_i) begin
            idx = beat_idx + (tl_d_valid_o ? 1 : 0);
            beat_idx <= idx;
            if (idx == beat_total) begin
                tl_d_valid_o <= 1'b0;
                responding   <= 1'b0;
            end else if (draw_stall()) begin
                tl_d_valid_o <= 1'b0;
            end else begin
                rsp        = '0;
                rsp.opcode = rsp_data ? TL_ACCESS_ACK_DATA : TL_ACCESS_ACK;
                rsp.denied = rsp_denied;
                for (int j = 0; j < 4; j++) begin
                    if (rsp_data && !rsp_denied) begin
                        rsp.data[8*j +: 8] = mem[base + addr_t'(4 * idx) + j];
                    end
                end
                tl_d_o       <= rsp;
                tl_d_valid_o <= 1'b1;
            end
        end
    end

endmodule

/* source/dmac_core.sv */
module dmac_core import dmac_pkg::*; (
    input  wire logic       dmac_clock_i,
    input  wire logic       arst_n_i,

    input  wire logic       tx_i,
    input  wire addr_t      src_addr_i,
    input  wire addr_t      dst_addr_i,
    input  wire addr_t      bytes_i,
    output logic            busy_o,
    output logic            done_o,
    output logic            err_o,

    output tl_a_req_t       tl_a_o,
    output logic            tl_a_valid_o,
    input  wire logic       tl_a_ready_i,
    input  wire tl_d_rsp_t  tl_d_i,
    input  wire logic       tl_d_valid_i,
    output logic            tl_d_ready_o
);

    burst_t  burst;
    addr_t   cur_src;
    addr_t   cur_dst;
    addr_t   remaining;
    logic    beat_push;
    logic    beat_pop;
    data_t   beat_head;
    logic    beat_empty;
    logic    beat_full;

    assign tl_d_ready_o = !beat_full;

    dmac_burst_sizer u_sizer (
        .src_addr_i   (cur_src),
        .dst_addr_i   (cur_dst),
        .remaining_i  (remaining),
        .burst_o      (burst)
    );

    dmac_beat_fifo u_fifo (
        .dmac_clock_i (dmac_clock_i),
        .arst_n_i     (arst_n_i),
        .push_i       (beat_push),
        .push_data_i  (tl_d_i.data),
        .pop_i        (beat_pop),
        .head_o       (beat_head),
        .empty_o      (beat_empty),
        .full_o       (beat_full)
    );

    dmac_channel_ctrl u_ctrl (
        .dmac_clock_i (dmac_clock_i),
        .arst_n_i     (arst_n_i),
        .tx_i         (tx_i),
        .src_addr_i   (src_addr_i),
        .dst_addr_i   (dst_addr_i),
        .bytes_i      (bytes_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .err_o        (err_o),
        .burst_i      (burst),
        .cur_src_o    (cur_src),
        .cur_dst_o    (cur_dst),
        .remaining_o  (remaining),
        .tl_a_o       (tl_a_o),
        .tl_a_valid_o (tl_a_valid_o),
        .tl_a_ready_i (tl_a_ready_i),
        .tl_d_i       (tl_d_i),
        .tl_d_valid_i (tl_d_valid_i),
        .beat_push_o  (beat_push),
        .beat_pop_o   (beat_pop),
        .beat_head_i  (beat_head),
        .beat_empty_i (beat_empty)
    );

endmodule

/* source/dmac_channel_ctrl.sv */
`include "dmac_config.svh"

module dmac_channel_ctrl import dmac_pkg::*; (
    input  wire logic       dmac_clock_i,
    input  wire logic       arst_n_i,

    input  wire logic       tx_i,
    input  wire addr_t      src_addr_i,
    input  wire addr_t      dst_addr_i,
    input  wire addr_t      bytes_i,
    output logic            busy_o,
    output logic            done_o,
    output logic            err_o,

    input  wire burst_t     burst_i,
    output addr_t           cur_src_o,
    output addr_t           cur_dst_o,
    output addr_t           remaining_o,

    output tl_a_req_t       tl_a_o,
    output logic            tl_a_valid_o,
    input  wire logic       tl_a_ready_i,
    input  wire tl_d_rsp_t  tl_d_i,
    input  wire logic       tl_d_valid_i,

    output logic            beat_push_o,
    output logic            beat_pop_o,
    input  wire data_t      beat_head_i,
    input  wire logic       beat_empty_i
);

    localparam int LANE_W = $clog2(`DMAC_DATA_BYTES);

    dmac_state_e        state_q;
    beat_cnt_t          beat_cnt_q;
    logic               err_q;

    addr_t              cur_src_q;
    addr_t              cur_dst_q;
    addr_t              remaining_q;
    burst_t             burst_q;
    logic [LANE_W-1:0]  src_lane_q;

    logic               a_fire;
    logic               d_bad;
    logic               last_beat;
    logic               drain;
    logic [LANE_W-1:0]  dst_lane;
    logic [LANE_W-1:0]  lane_shift;
    data_t              put_data;
    mask_t              put_mask;
    addr_t              put_addr;
    addr_t              dst_step;

    assign busy_o = (state_q != IDLE);
    assign done_o = (state_q == FINISH);
    assign err_o  = (state_q == FINISH) && err_q;

    assign cur_src_o   = cur_src_q;
    assign cur_dst_o   = cur_dst_q;
    assign remaining_o = remaining_q;

    assign d_bad     = tl_d_i.denied || tl_d_i.corrupt;
    assign last_beat = (beat_cnt_q == burst_q.beats - 1'b1);
    assign a_fire    = tl_a_valid_o && tl_a_ready_i;

    // beats left behind by a failed burst are flushed before the next Get
    assign drain = ((state_q == IDLE) || (state_q == READ_REQ)) && !beat_empty_i;

    assign beat_push_o = (state_q == READ_WAIT) && tl_d_valid_i &&
                         (tl_d_i.opcode == TL_ACCESS_ACK_DATA);
    assign beat_pop_o  = drain || ((state_q == WRITE_REQ) && a_fire);

    always_comb begin
        tl_a_valid_o = 1'b0;
        if (state_q == READ_REQ) begin
            tl_a_valid_o = (remaining_q != '0) && beat_empty_i;
        end else if (state_q == WRITE_REQ) begin
            tl_a_valid_o = !beat_empty_i;
        end
    end

    // move a sub-word beat from the source lane to the destination lane
    assign dst_lane   = cur_dst_q[LANE_W-1:0];
    assign lane_shift = dst_lane - src_lane_q;

    always_comb begin
        logic [5:0] bit_shift;
        bit_shift = {lane_shift, 3'b000};
        put_data  = (beat_head_i << bit_shift) | (beat_head_i >> (6'd32 - bit_shift));
        if (lane_shift == '0) begin
            put_data = beat_head_i;
        end
    end

    always_comb begin
        if (burst_q.lgsize < lgsize_t'(LANE_W)) begin
            put_mask = mask_t'(((1 << burst_q.bytes) - 1) << dst_lane);
            dst_step = burst_q.bytes;
        end else begin
            put_mask = '1;
            dst_step = addr_t'(`DMAC_DATA_BYTES);
        end
    end

    // every beat of a burst carries the burst base address
    assign put_addr = cur_dst_q & ~(burst_q.bytes - 1'b1);

    always_comb begin
        tl_a_o.param   = '0;
        tl_a_o.corrupt = 1'b0;
        if (state_q == READ_REQ) begin
            tl_a_o.opcode  = TL_GET;
            tl_a_o.size    = burst_i.lgsize;
            tl_a_o.address = cur_src_q;
            tl_a_o.mask    = '0;
            tl_a_o.data    = '0;
        end else begin
            tl_a_o.opcode  = TL_PUT_FULL_DATA;
            tl_a_o.size    = burst_q.lgsize;
            tl_a_o.address = put_addr;
            tl_a_o.mask    = put_mask;
            tl_a_o.data    = put_data;
        end
    end

    always_ff @(posedge dmac_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= IDLE;
            beat_cnt_q <= '0;
            err_q      <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (tx_i) begin
                        err_q   <= 1'b0;
                        state_q <= READ_REQ;
                    end
                end
                READ_REQ: begin
                    if (remaining_q == '0) begin
                        state_q <= FINISH;
                    end else if (a_fire) begin
                        beat_cnt_q <= '0;
                        state_q    <= READ_WAIT;
                    end
                end
                READ_WAIT: begin
                    // a failed burst still runs to its last beat
                    if (tl_d_valid_i) begin
                        if (d_bad) begin
                            err_q <= 1'b1;
                        end
                        if (last_beat) begin
                            beat_cnt_q <= '0;
                            state_q    <= (err_q || d_bad) ? FINISH : WRITE_REQ;
                        end else begin
                            beat_cnt_q <= beat_cnt_q + 1'b1;
                        end
                    end
                end
                WRITE_REQ: begin
                    if (a_fire) begin
                        if (last_beat) begin
                            beat_cnt_q <= '0;
                            state_q    <= WRITE_ACK;
                        end else begin
                            beat_cnt_q <= beat_cnt_q + 1'b1;
                        end
                    end
                end
                WRITE_ACK: begin
                    if (tl_d_valid_i && (tl_d_i.opcode == TL_ACCESS_ACK)) begin
                        if (d_bad) begin
                            err_q <= 1'b1;
                        end
                        state_q <= (d_bad || remaining_q == '0) ? FINISH : READ_REQ;
                    end
                end
                FINISH: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge dmac_clock_i) begin
        if ((state_q == IDLE) && tx_i) begin
            cur_src_q   <= src_addr_i;
            cur_dst_q   <= dst_addr_i;
            remaining_q <= bytes_i;
        end
        if ((state_q == READ_REQ) && a_fire) begin
            burst_q     <= burst_i;
            src_lane_q  <= cur_src_q[LANE_W-1:0];
            cur_src_q   <= cur_src_q + burst_i.bytes;
            remaining_q <= remaining_q - burst_i.bytes;
        end
        if ((state_q == WRITE_REQ) && a_fire) begin
            cur_dst_q <= cur_dst_q + dst_step;
        end
    end

endmodule

/* source/dmac_beat_fifo.sv */
`include "dmac_config.svh"

module dmac_beat_fifo import dmac_pkg::*; #(
    parameter int DEPTH = `DMAC_FIFO_DEPTH
) (
    input  wire logic   dmac_clock_i,
    input  wire logic   arst_n_i,
    input  wire logic   push_i,
    input  wire data_t  push_data_i,
    input  wire logic   pop_i,
    output data_t       head_o,
    output logic        empty_o,
    output logic        full_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    data_t             mem [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              do_push;
    logic              do_pop;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign head_o  = mem[rd_ptr_q];

    always_ff @(posedge dmac_clock_i) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge dmac_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

/* source/dmac_burst_sizer.sv */
`include "dmac_config.svh"

module dmac_burst_sizer import dmac_pkg::*; (
    input  wire addr_t  src_addr_i,
    input  wire addr_t  dst_addr_i,
    input  wire addr_t  remaining_i,
    output burst_t      burst_o
);

    localparam int LANE_W = $clog2(`DMAC_DATA_BYTES);

    // lowest set bit, capped at the largest burst
    function automatic lgsize_t align_log(input addr_t value);
        lgsize_t result;
        result = lgsize_t'(`DMAC_MAX_BURST_LOG);
        // scan downwards so the last hit is the lowest one
        for (int i = `DMAC_MAX_BURST_LOG - 1; i >= 0; i--) begin
            if (value[i]) begin
                result = lgsize_t'(i);
            end
        end
        return result;
    endfunction

    lgsize_t src_log;
    lgsize_t dst_log;
    lgsize_t rem_log;
    lgsize_t min_log;
    addr_t   burst_bytes;

    always_comb begin
        src_log = align_log(src_addr_i);
        dst_log = align_log(dst_addr_i);
        rem_log = align_log(remaining_i);
    end

    // smallest of the three limits
    always_comb begin
        min_log = src_log;
        if (dst_log < min_log) begin
            min_log = dst_log;
        end
        if (rem_log < min_log) begin
            min_log = rem_log;
        end
    end

    assign burst_bytes = addr_t'(1) << min_log;

    always_comb begin
        burst_o.lgsize = min_log;
        burst_o.bytes  = burst_bytes;
        // sub-word bursts still take a whole beat
        if (min_log < lgsize_t'(LANE_W)) begin
            burst_o.beats = beat_cnt_t'(1);
        end else begin
            burst_o.beats = beat_cnt_t'(burst_bytes >> LANE_W);
        end
    end

endmodule

/* source/dmac_pkg.sv */
`include "dmac_config.svh"

package dmac_pkg;

    typedef logic [`DMAC_ADDR_W-1:0]       addr_t;
    typedef logic [8*`DMAC_DATA_BYTES-1:0] data_t;
    typedef logic [`DMAC_DATA_BYTES-1:0]   mask_t;
    typedef logic [3:0]                    lgsize_t;
    typedef logic [5:0]                    beat_cnt_t;

    // tilelink-ul channel a opcodes
    typedef enum logic [2:0] {
        TL_PUT_FULL_DATA = 3'd0,
        TL_GET           = 3'd4
    } tl_a_op_e;

    // tilelink-ul channel d opcodes
    typedef enum logic [2:0] {
        TL_ACCESS_ACK      = 3'd0,
        TL_ACCESS_ACK_DATA = 3'd1
    } tl_d_op_e;

    typedef struct packed {
        tl_a_op_e   opcode;
        logic [2:0] param;
        lgsize_t    size;
        addr_t      address;
        mask_t      mask;
        data_t      data;
        logic       corrupt;
    } tl_a_req_t;

    typedef struct packed {
        tl_d_op_e   opcode;
        logic [1:0] param;
        lgsize_t    size;
        logic       denied;
        data_t      data;
        logic       corrupt;
    } tl_d_rsp_t;

    typedef struct packed {
        lgsize_t   lgsize;
        addr_t     bytes;
        beat_cnt_t beats;
    } burst_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_REQ,
        READ_WAIT,
        WRITE_REQ,
        WRITE_ACK,
        FINISH
    } dmac_state_e;

endpackage

/* source/dmac_config.svh */
`ifndef DMAC_CONFIG_SVH
`define DMAC_CONFIG_SVH

// address and byte count width
`define DMAC_ADDR_W 32

// bytes carried by one data beat
`define DMAC_DATA_BYTES 4

// largest burst is 2**7 = 128 bytes
`define DMAC_MAX_BURST_LOG 7

// one maximum burst worth of beats
`define DMAC_FIFO_DEPTH 32

`endif
